/* tb.f */
+incdir+include
src/fft16_pkg.sv
src/fft16_sample_loader.sv
src/fft16_pass_sched.sv
src/fft16_twiddle_rom.sv
src/fft16_radix4_engine.sv
src/fft16_output_serializer.sv
src/fft16_top.sv
dv/tb_clock_gen.sv
dv/tb_fft16.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FFT testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fft16 \
  -Mdir obj_dir -f tb.f
out=$(./obj_dir/Vtb_fft16)
echo "$out"
if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* dv/tb_fft16.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module tb_fft16;

  localparam int  N          = `FFT_N;
  localparam int  MAX_FRAMES = 8;
  localparam int  LATENCY    = 20;
  localparam int  WAIT_LIMIT = 64;
  localparam real PI         = 3.14159265358979;

  logic               clk;
  logic               rst_n;
  fft16_pkg::sample_t in_re;
  fft16_pkg::sample_t in_im;
  fft16_pkg::sample_t out_re;
  fft16_pkg::sample_t out_im;
  logic               out_valid;
  logic               out_first;

  // Stimulus and expected bins, one frame per entry
  fft16_pkg::frame_vec_t stim_re [0:MAX_FRAMES-1];
  fft16_pkg::frame_vec_t stim_im [0:MAX_FRAMES-1];
  fft16_pkg::frame_vec_t exp_re  [0:MAX_FRAMES-1];
  fft16_pkg::frame_vec_t exp_im  [0:MAX_FRAMES-1];

  int sample_edge  = 0;
  int mismatch_cnt = 0;
  int fail_cnt     = 0;
  int seed;

  tb_clock_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fft16_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .in_re_i     (in_re),
    .in_im_i     (in_im),
    .out_re_o    (out_re),
    .out_im_o    (out_im),
    .out_valid_o (out_valid),
    .out_first_o (out_first)
  );

  // Rising edges out of reset, also the index of the next sample
  always @(posedge clk) begin
    if (rst_n) begin
      sample_edge <= sample_edge + 1;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_bin(input int bin, input fft16_pkg::sample_t e_re,
                           input fft16_pkg::sample_t e_im, input fft16_pkg::sample_t a_re,
                           input fft16_pkg::sample_t a_im);
    if (a_re !== e_re || a_im !== e_im) begin
      $display("Mismatch at %0t: bin %0d expected (%0d, %0d) got (%0d, %0d)",
               $time, bin, e_re, e_im, a_re, a_im);
      mismatch_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic e_val, input logic a_val);
    if (a_val !== e_val) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, e_val, a_val);
      mismatch_cnt++;
    end
  endtask

  task automatic check_latency(input int e_val, input int a_val);
    if (a_val != e_val) begin
      $display("Mismatch at %0t: latency expected %0d cycles got %0d", $time, e_val, a_val);
      mismatch_cnt++;
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int tw_re_of(input int m);
    return int'(16384.0 * $cos(2.0 * PI * m / N));
  endfunction

  function automatic int tw_im_of(input int m);
    return int'(-16384.0 * $sin(2.0 * PI * m / N));
  endfunction

  function automatic longint to_long(input fft16_pkg::sample_t v);
    return longint'(v);
  endfunction

  // Twiddle multiply then 4-point DFT, scaled per pass
  task automatic radix4_model(input longint op_re [0:3], input longint op_im [0:3],
                              input fft16_pkg::pass_e pass, input int lane,
                              output fft16_pkg::sample_t res_re [0:3],
                              output fft16_pkg::sample_t res_im [0:3]);
    longint m_re [0:3];
    longint m_im [0:3];
    longint w_re;
    longint w_im;
    longint s_re;
    longint s_im;
    int     e;
    int     rr;
    int     ri;
    m_re[0] = op_re[0];
    m_im[0] = op_im[0];
    for (int p = 1; p < 4; p++) begin
      e = (pass == fft16_pkg::PASS_TWO) ? p * lane : 0;
      w_re = tw_re_of(e);
      w_im = tw_im_of(e);
      m_re[p] = (op_re[p] * w_re - op_im[p] * w_im) >>> `FFT_TW_FRAC;
      m_im[p] = (op_re[p] * w_im + op_im[p] * w_re) >>> `FFT_TW_FRAC;
    end
    // X_k sums operand p rotated by (-j)^(p*k)
    for (int k = 0; k < 4; k++) begin
      s_re = 0;
      s_im = 0;
      for (int p = 0; p < 4; p++) begin
        e  = (p * k) % 4;
        rr = (e == 0) ? 1 : ((e == 2) ? -1 : 0);
        ri = (e == 1) ? -1 : ((e == 3) ? 1 : 0);
        s_re += m_re[p] * rr - m_im[p] * ri;
        s_im += m_re[p] * ri + m_im[p] * rr;
      end
      res_re[k] = fft16_pkg::sample_t'(s_re >>> `FFT_PASS_SHIFT);
      res_im[k] = fft16_pkg::sample_t'(s_im >>> `FFT_PASS_SHIFT);
    end
  endtask

  task automatic model_frame(input int f);
    longint             op_re   [0:3];
    longint             op_im   [0:3];
    fft16_pkg::sample_t lane_re [0:3];
    fft16_pkg::sample_t lane_im [0:3];
    fft16_pkg::sample_t y_re    [0:3][0:3];
    fft16_pkg::sample_t y_im    [0:3][0:3];
    // Pass one, lane n2 takes samples 4*n1 + n2
    for (int n2 = 0; n2 < 4; n2++) begin
      for (int p = 0; p < 4; p++) begin
        op_re[p] = to_long(stim_re[f][4 * p + n2]);
        op_im[p] = to_long(stim_im[f][4 * p + n2]);
      end
      radix4_model(op_re, op_im, fft16_pkg::PASS_ONE, n2, lane_re, lane_im);
      for (int k1 = 0; k1 < 4; k1++) begin
        y_re[n2][k1] = lane_re[k1];
        y_im[n2][k1] = lane_im[k1];
      end
    end
    // Pass two on the transpose, lane k1 element k2 is bin k1 + 4*k2
    for (int k1 = 0; k1 < 4; k1++) begin
      for (int p = 0; p < 4; p++) begin
        op_re[p] = to_long(y_re[p][k1]);
        op_im[p] = to_long(y_im[p][k1]);
      end
      radix4_model(op_re, op_im, fft16_pkg::PASS_TWO, k1, lane_re, lane_im);
      for (int k2 = 0; k2 < 4; k2++) begin
        exp_re[f][k1 + 4 * k2] = lane_re[k2];
        exp_im[f][k1 + 4 * k2] = lane_im[k2];
      end
    end
  endtask

  //////////////////////////////
  // Stream drive and capture
  //////////////////////////////

  task automatic align_frame(output int start);
    int guard;
    guard = 0;
    @(negedge clk);
    while ((sample_edge % N) != 0 && guard < 2 * N) begin
      @(negedge clk);
      guard++;
    end
    if ((sample_edge % N) != 0) begin
      $display("Timeout at %0t: frame boundary never reached", $time);
      fail_cnt++;
    end
    start = sample_edge;
  endtask

  task automatic drive_frames(input int count);
    for (int i = 0; i < count * N; i++) begin
      if (i != 0) begin
        @(negedge clk);
      end
      in_re = stim_re[i / N][i % N];
      in_im = stim_im[i / N][i % N];
    end
    @(negedge clk);
    in_re = '0;
    in_im = '0;
  endtask

  // Skips the bins of the previous frame, then checks count frames back to back
  task automatic collect_frames(input int start, input int count, input bit quiet);
    int guard;
    bit found;
    guard = 0;
    found = 1'b0;
    while (!found && guard < WAIT_LIMIT) begin
      @(negedge clk);
      guard++;
      if (out_first === 1'b1 && sample_edge > start + 8) begin
        found = 1'b1;
      end else if (quiet) begin
        check_flag("out_valid_o", 1'b0, out_valid);
      end
    end
    if (!found) begin
      $display("Timeout at %0t: no first bin for the frame sampled from edge %0d",
               $time, start);
      fail_cnt++;
      return;
    end
    check_latency(LATENCY, sample_edge - 1 - start);
    for (int f = 0; f < count; f++) begin
      for (int b = 0; b < N; b++) begin
        if (f != 0 || b != 0) begin
          @(negedge clk);
        end
        check_flag("out_valid_o", 1'b1, out_valid);
        check_flag("out_first_o", b == 0, out_first);
        check_bin(b, exp_re[f][b], exp_im[f][b], out_re, out_im);
      end
    end
  endtask

  task automatic run_frames(input int count);
    int start;
    align_frame(start);
    fork
      drive_frames(count);
      collect_frames(start, count, 1'b0);
    join
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  // Frame 0 carries the idle zero input from reset
  task automatic reset_and_latency();
    check_flag("out_valid_o", 1'b0, out_valid);
    check_flag("out_first_o", 1'b0, out_first);
    check_bin(0, '0, '0, out_re, out_im);
    stim_re[0] = '0;
    stim_im[0] = '0;
    model_frame(0);
    collect_frames(0, 1, 1'b1);
  endtask

  task automatic impulse_frame();
    fft16_pkg::sample_t a_re;
    fft16_pkg::sample_t a_im;
    a_re = 16'sd7000;
    a_im = -16'sd5000;
    stim_re[0] = '0;
    stim_im[0] = '0;
    stim_re[0][0] = a_re;
    stim_im[0][0] = a_im;
    // Both passes shift by 2
    for (int k = 0; k < N; k++) begin
      exp_re[0][k] = a_re >>> (2 * `FFT_PASS_SHIFT);
      exp_im[0][k] = a_im >>> (2 * `FFT_PASS_SHIFT);
    end
    run_frames(1);
  endtask

  task automatic dc_frame();
    for (int n = 0; n < N; n++) begin
      stim_re[0][n] = 16'sd1200;
      stim_im[0][n] = -16'sd800;
    end
    model_frame(0);
    run_frames(1);
  endtask

  task automatic tone_frame();
    for (int n = 0; n < N; n++) begin
      stim_re[0][n] = fft16_pkg::sample_t'(int'(6000.0 * $cos(2.0 * PI * 3 * n / N)));
      stim_im[0][n] = fft16_pkg::sample_t'(int'(6000.0 * $sin(2.0 * PI * 3 * n / N)));
    end
    model_frame(0);
    run_frames(1);
  endtask

  task automatic random_frames();
    for (int f = 0; f < MAX_FRAMES; f++) begin
      for (int n = 0; n < N; n++) begin
        stim_re[f][n] = fft16_pkg::sample_t'($random(seed) % 8192);
        stim_im[f][n] = fft16_pkg::sample_t'($random(seed) % 8192);
      end
      model_frame(f);
    end
    run_frames(MAX_FRAMES);
  endtask

  initial begin
    int guard;
    in_re = '0;
    in_im = '0;
    seed  = 32'h97458886;
    guard = 0;
    do begin
      @(negedge clk);
      guard++;
    end while (rst_n !== 1'b1 && guard < 20);
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      fail_cnt++;
    end
    reset_and_latency();
    impulse_frame();
    dc_frame();
    tone_frame();
    random_frames();
    $display("Summary: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for three cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* src/fft16_top.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  fft16_pkg::sample_t  in_re_i,
  input  fft16_pkg::sample_t  in_im_i,
  output fft16_pkg::sample_t  out_re_o,
  output fft16_pkg::sample_t  out_im_o,
  output logic                out_valid_o,
  output logic                out_first_o
);

  // Loader to scheduler
  fft16_pkg::frame_vec_t frame_re;
  fft16_pkg::frame_vec_t frame_im;
  logic                  frame_ready;

  // Scheduler to engines and ROM
  fft16_pkg::lane_vec_t  opa_re [0:`FFT_RADIX-1];
  fft16_pkg::lane_vec_t  opa_im [0:`FFT_RADIX-1];
  fft16_pkg::pass_e      pass_sel;
  logic                  frame_done;

  // Twiddles per lane
  fft16_pkg::tw_lane_t   tw_re [0:`FFT_RADIX-1];
  fft16_pkg::tw_lane_t   tw_im [0:`FFT_RADIX-1];

  // Engine results, fed back and serialised
  fft16_pkg::lane_vec_t  res_re [0:`FFT_RADIX-1];
  fft16_pkg::lane_vec_t  res_im [0:`FFT_RADIX-1];

  //////////////////////////////
  // Framing and scheduling
  //////////////////////////////

  fft16_sample_loader u_loader (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .in_re_i       (in_re_i),
    .in_im_i       (in_im_i),
    .frame_re_o    (frame_re),
    .frame_im_o    (frame_im),
    .frame_ready_o (frame_ready)
  );

  fft16_pass_sched u_sched (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .frame_ready_i (frame_ready),
    .frame_re_i    (frame_re),
    .frame_im_i    (frame_im),
    .res_re_i      (res_re),
    .res_im_i      (res_im),
    .opa_re_o      (opa_re),
    .opa_im_o      (opa_im),
    .pass_o        (pass_sel),
    .frame_done_o  (frame_done)
  );

  fft16_twiddle_rom u_tw_rom (
    .pass_i  (pass_sel),
    .tw_re_o (tw_re),
    .tw_im_o (tw_im)
  );

  //////////////////////////////
  // Radix-4 lanes
  //////////////////////////////

  for (genvar l = 0; l < `FFT_RADIX; l++) begin : g_lane
    fft16_radix4_engine u_engine (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .op_re_i  (opa_re[l]),
      .op_im_i  (opa_im[l]),
      .tw_re_i  (tw_re[l]),
      .tw_im_i  (tw_im[l]),
      .res_re_o (res_re[l]),
      .res_im_o (res_im[l])
    );
  end

  fft16_output_serializer u_serializer (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .frame_done_i (frame_done),
    .res_re_i     (res_re),
    .res_im_i     (res_im),
    .out_re_o     (out_re_o),
    .out_im_o     (out_im_o),
    .out_valid_o  (out_valid_o),
    .out_first_o  (out_first_o)
  );

endmodule

/* src/fft16_output_serializer.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_output_serializer (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  frame_done_i,
  input  fft16_pkg::lane_vec_t  res_re_i [0:`FFT_RADIX-1],
  input  fft16_pkg::lane_vec_t  res_im_i [0:`FFT_RADIX-1],
  output fft16_pkg::sample_t    out_re_o,
  output fft16_pkg::sample_t    out_im_o,
  output logic                  out_valid_o,
  output logic                  out_first_o
);

  localparam int IDX_W = $clog2(`FFT_N);

  fft16_pkg::frame_vec_t bank_re_q;
  fft16_pkg::frame_vec_t bank_im_q;
  logic [IDX_W-1:0]      idx_q;
  logic                  running_q;

  // Lane k1 element k2 lands in bin k1 + 4*k2
  always_ff @(posedge clk) begin
    if (frame_done_i) begin
      for (int k1 = 0; k1 < `FFT_RADIX; k1++) begin
        for (int k2 = 0; k2 < `FFT_RADIX; k2++) begin
          bank_re_q[k1 + `FFT_RADIX*k2] <= res_re_i[k1][k2];
          bank_im_q[k1 + `FFT_RADIX*k2] <= res_im_i[k1][k2];
        end
      end
    end
  end

  //////////////////////////////
  // Bin index and output stage
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q       <= '0;
      running_q   <= 1'b0;
      out_re_o    <= '0;
      out_im_o    <= '0;
      out_valid_o <= 1'b0;
      out_first_o <= 1'b0;
    end else begin
      if (frame_done_i) begin
        idx_q     <= '0;
        running_q <= 1'b1;
      end else if (running_q) begin
        idx_q <= idx_q + 1'b1;
      end
      // Old bank is still read on the capture edge
      if (running_q) begin
        out_re_o    <= bank_re_q[idx_q];
        out_im_o    <= bank_im_q[idx_q];
        out_valid_o <= 1'b1;
        out_first_o <= (idx_q == '0);
      end
    end
  end

  // New frame may only overwrite the bank as the last bin leaves
  a_done_aligned : assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_done_i |-> (!running_q || idx_q == IDX_W'(`FFT_N - 1)));

endmodule

/* src/fft16_radix4_engine.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_radix4_engine (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  fft16_pkg::lane_vec_t  op_re_i,
  input  fft16_pkg::lane_vec_t  op_im_i,
  input  fft16_pkg::tw_lane_t   tw_re_i,
  input  fft16_pkg::tw_lane_t   tw_im_i,
  output fft16_pkg::lane_vec_t  res_re_o,
  output fft16_pkg::lane_vec_t  res_im_o
);

  localparam int R      = `FFT_RADIX;
  localparam int PROD_W = `FFT_SAMPLE_W + `FFT_TW_W + 1;

  fft16_pkg::sample_t      a_re [0:R-1];
  fft16_pkg::sample_t      a_im [0:R-1];
  fft16_pkg::twiddle_t     c_re [1:R-1];
  fft16_pkg::twiddle_t     c_im [1:R-1];
  logic signed [PROD_W-1:0] p_re [1:R-1];
  logic signed [PROD_W-1:0] p_im [1:R-1];
  fft16_pkg::acc_t         m_re [0:R-1];
  fft16_pkg::acc_t         m_im [0:R-1];
  fft16_pkg::acc_t         x_re [0:R-1];
  fft16_pkg::acc_t         x_im [0:R-1];

  //////////////////////////////
  // Twiddle multiply
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < R; i++) begin
      a_re[i] = op_re_i[i];
      a_im[i] = op_im_i[i];
    end
    // Position 0 passes straight to the butterfly
    m_re[0] = fft16_pkg::acc_t'(a_re[0]);
    m_im[0] = fft16_pkg::acc_t'(a_im[0]);
    for (int i = 1; i < R; i++) begin
      c_re[i] = tw_re_i[i-1];
      c_im[i] = tw_im_i[i-1];
      // Full precision, then drop the Q1.14 fraction
      p_re[i] = a_re[i] * c_re[i] - a_im[i] * c_im[i];
      p_im[i] = a_re[i] * c_im[i] + a_im[i] * c_re[i];
      m_re[i] = fft16_pkg::acc_t'(p_re[i] >>> `FFT_TW_FRAC);
      m_im[i] = fft16_pkg::acc_t'(p_im[i] >>> `FFT_TW_FRAC);
    end
  end

  //////////////////////////////
  // 4-point butterfly
  //////////////////////////////

  // Multiplying by -j maps (re, im) to (im, -re)
  always_comb begin
    x_re[0] = m_re[0] + m_re[1] + m_re[2] + m_re[3];
    x_im[0] = m_im[0] + m_im[1] + m_im[2] + m_im[3];
    x_re[1] = m_re[0] + m_im[1] - m_re[2] - m_im[3];
    x_im[1] = m_im[0] - m_re[1] - m_im[2] + m_re[3];
    x_re[2] = m_re[0] - m_re[1] + m_re[2] - m_re[3];
    x_im[2] = m_im[0] - m_im[1] + m_im[2] - m_im[3];
    x_re[3] = m_re[0] - m_im[1] - m_re[2] + m_im[3];
    x_im[3] = m_im[0] + m_re[1] - m_im[2] - m_re[3];
  end

  // Pass scaling and output register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_re_o <= '0;
      res_im_o <= '0;
    end else begin
      for (int k = 0; k < R; k++) begin
        res_re_o[k] <= fft16_pkg::sample_t'(x_re[k] >>> `FFT_PASS_SHIFT);
        res_im_o[k] <= fft16_pkg::sample_t'(x_im[k] >>> `FFT_PASS_SHIFT);
      end
    end
  end

endmodule

/* src/fft16_twiddle_rom.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_twiddle_rom (
  input  fft16_pkg::pass_e     pass_i,
  output fft16_pkg::tw_lane_t  tw_re_o [0:`FFT_RADIX-1],
  output fft16_pkg::tw_lane_t  tw_im_o [0:`FFT_RADIX-1]
);

  // Real part of W^m, round(16384*cos(2*pi*m/16))
  function automatic fft16_pkg::twiddle_t tw_cos(input int m);
    case (m)
      1:       return 16'sd15137;
      2:       return 16'sd11585;
      3:       return 16'sd6270;
      4:       return 16'sd0;
      6:       return -16'sd11585;
      9:       return -16'sd15137;
      default: return 16'sd16384;
    endcase
  endfunction

  // Imaginary part, round(-16384*sin(2*pi*m/16))
  function automatic fft16_pkg::twiddle_t tw_nsin(input int m);
    case (m)
      1:       return -16'sd6270;
      2:       return -16'sd11585;
      3:       return -16'sd15137;
      4:       return -16'sd16384;
      6:       return -16'sd11585;
      9:       return 16'sd6270;
      default: return 16'sd0;
    endcase
  endfunction

  // Lane k1, position n2 takes W^(n2*k1) in pass two, unity otherwise
  always_comb begin
    for (int l = 0; l < `FFT_RADIX; l++) begin
      for (int p = 1; p < `FFT_RADIX; p++) begin
        if (pass_i == fft16_pkg::PASS_TWO) begin
          tw_re_o[l][p-1] = tw_cos(p * l);
          tw_im_o[l][p-1] = tw_nsin(p * l);
        end else begin
          tw_re_o[l][p-1] = tw_cos(0);
          tw_im_o[l][p-1] = tw_nsin(0);
        end
      end
    end
  end

endmodule

/* src/fft16_pass_sched.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_pass_sched (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   frame_ready_i,
  input  fft16_pkg::frame_vec_t  frame_re_i,
  input  fft16_pkg::frame_vec_t  frame_im_i,
  input  fft16_pkg::lane_vec_t   res_re_i [0:`FFT_RADIX-1],
  input  fft16_pkg::lane_vec_t   res_im_i [0:`FFT_RADIX-1],
  output fft16_pkg::lane_vec_t   opa_re_o [0:`FFT_RADIX-1],
  output fft16_pkg::lane_vec_t   opa_im_o [0:`FFT_RADIX-1],
  output fft16_pkg::pass_e       pass_o,
  output logic                   frame_done_o
);

  fft16_pkg::pass_e pass_q;

  //////////////////////////////
  // Pass FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pass_q       <= fft16_pkg::PASS_IDLE;
      frame_done_o <= 1'b0;
    end else begin
      // Pass-two results are on the engine outputs one cycle later
      frame_done_o <= (pass_q == fft16_pkg::PASS_TWO);
      case (pass_q)
        fft16_pkg::PASS_IDLE: begin
          if (frame_ready_i) begin
            pass_q <= fft16_pkg::PASS_ONE;
          end
        end
        fft16_pkg::PASS_ONE: pass_q <= fft16_pkg::PASS_TWO;
        default:             pass_q <= fft16_pkg::PASS_IDLE;
      endcase
    end
  end

  assign pass_o = pass_q;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Pass one gathers column n2, pass two feeds back the transpose
  always_comb begin
    for (int l = 0; l < `FFT_RADIX; l++) begin
      for (int p = 0; p < `FFT_RADIX; p++) begin
        if (pass_q == fft16_pkg::PASS_TWO) begin
          opa_re_o[l][p] = res_re_i[p][l];
          opa_im_o[l][p] = res_im_i[p][l];
        end else begin
          opa_re_o[l][p] = frame_re_i[`FFT_RADIX*p + l];
          opa_im_o[l][p] = frame_im_i[`FFT_RADIX*p + l];
        end
      end
    end
  end

  a_two_after_one : assert property (@(posedge clk) disable iff (!rst_n_i)
    pass_q == fft16_pkg::PASS_TWO |-> $past(pass_q) == fft16_pkg::PASS_ONE);

  // Loader period must cover both passes
  a_ready_when_idle : assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_ready_i |-> pass_q == fft16_pkg::PASS_IDLE);

endmodule

/* src/fft16_sample_loader.sv */
`timescale 1ns/100ps
`include "fft16_cfg.svh"

module fft16_sample_loader (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  fft16_pkg::sample_t     in_re_i,
  input  fft16_pkg::sample_t     in_im_i,
  output fft16_pkg::frame_vec_t  frame_re_o,
  output fft16_pkg::frame_vec_t  frame_im_o,
  output logic                   frame_ready_o
);

  localparam int CNT_W = $clog2(`FFT_N);
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`FFT_N - 1);

  logic [CNT_W-1:0] cnt_q;

  // Capture bank, the last sample bypasses it
  fft16_pkg::sample_t cap_re_q [0:`FFT_N-2];
  fft16_pkg::sample_t cap_im_q [0:`FFT_N-2];

  // Free-running slot counter, frame boundary fixed by reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q         <= '0;
      frame_ready_o <= 1'b0;
    end else begin
      cnt_q         <= cnt_q + 1'b1;
      frame_ready_o <= (cnt_q == LAST_IDX);
    end
  end

  // Fill slots, then move the whole frame to the hold bank at index 15
  always_ff @(posedge clk) begin
    if (cnt_q != LAST_IDX) begin
      cap_re_q[cnt_q] <= in_re_i;
      cap_im_q[cnt_q] <= in_im_i;
    end else begin
      for (int i = 0; i < `FFT_N - 1; i++) begin
        frame_re_o[i] <= cap_re_q[i];
        frame_im_o[i] <= cap_im_q[i];
      end
      frame_re_o[`FFT_N-1] <= in_re_i;
      frame_im_o[`FFT_N-1] <= in_im_i;
    end
  end

  // A new frame needs a full frame period
  for (genvar k = 1; k < `FFT_N; k++) begin : g_gap_chk
    a_ready_gap : assert property (@(posedge clk) disable iff (!rst_n_i)
      frame_ready_o |-> !$past(frame_ready_o, k));
  end

endmodule

/* src/fft16_pkg.sv */
`include "fft16_cfg.svh"

package fft16_pkg;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

  // Q1.14 twiddle component
  typedef logic signed [`FFT_TW_W-1:0] twiddle_t;

  // Internal butterfly sum
  typedef logic signed [`FFT_ACC_W-1:0] acc_t;

  //////////////////////////////
  // Grouped types
  //////////////////////////////

  // Operands or results of one radix-4 engine
  typedef sample_t [`FFT_RADIX-1:0] lane_vec_t;

  // One component of a whole frame
  typedef sample_t [`FFT_N-1:0] frame_vec_t;

  // Twiddles for positions 1 to 3, position 0 is never multiplied
  typedef twiddle_t [`FFT_RADIX-2:0] tw_lane_t;

  // Scheduler state, also picks the twiddle set
  typedef enum logic [1:0] {
    PASS_IDLE,
    PASS_ONE,
    PASS_TWO
  } pass_e;

endpackage

/* include/fft16_cfg.svh */
`ifndef FFT16_CFG_SVH
`define FFT16_CFG_SVH

// Frame geometry
`define FFT_N 16
`define FFT_RADIX 4

// Sample and twiddle widths
`define FFT_SAMPLE_W 16
`define FFT_TW_W 16

// Twiddles are Q1.14
`define FFT_TW_FRAC 14

// Butterfly sums need headroom over the sample width
`define FFT_ACC_W 20

// Right shift after every butterfly pass
`define FFT_PASS_SHIFT 2

`endif
